//--- files.f
design/audio_eq_pkg.sv
design/coef_bank.sv
design/biquad_section.sv
design/output_stage.sv
design/audio_eq_top.sv
tb/audio_eq_properties.sv
tb/audio_eq_tb.sv

//--- Bender.yml
package:
  name: audio_eq

sources:
  - files:
      - design/audio_eq_pkg.sv
      - design/coef_bank.sv
      - design/biquad_section.sv
      - design/output_stage.sv
      - design/audio_eq_top.sv
  - target: test
    files:
      - tb/audio_eq_properties.sv
      - tb/audio_eq_tb.sv

//--- tb/audio_eq_tb.sv
`timescale 1ns/1ns
// Self-checking testbench with a bit-exact model in 64-bit integers
// One sample every 6 cycles, so at most one sample is in the cascade
module audio_eq_tb;

    // About 300 samples at 6 cycles plus coefficient writes need under 2500 cycles
    localparam int max_cycles = 8000;
    localparam longint full_scale = 8388607;
    localparam int ns = audio_eq_pkg::num_sections;
    localparam int nc = audio_eq_pkg::coefs_per_section;

    logic clk;
    logic reset;
    audio_eq_pkg::sample_t sample_in;
    logic in_valid;
    logic coef_we;
    audio_eq_pkg::coef_addr_t coef_addr;
    audio_eq_pkg::coef_t coef_data;
    logic coef_commit;
    logic bypass;
    logic clip_clear;
    audio_eq_pkg::sample_t out_sample;
    logic out_valid;
    logic clip;

    // Model coefficients, shadow and committed
    longint shadow_m [ns][nc];
    longint active_m [ns][nc];
    // Model histories per section
    longint hx1 [ns];
    longint hx2 [ns];
    longint hy1 [ns];
    longint hy2 [ns];
    bit clip_m;
    audio_eq_pkg::sample_t exp_sample [$];
    logic exp_clip [$];
    int cycle_count;

    audio_eq_top u_dut (.*);

    always #20 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        assert (got === exp)
        else report_failure($sformatf("error: %s is %h, expected %h", name, got, exp));
    endtask

    function automatic longint rand_signed(input longint span);
        return longint'($urandom_range(32'(2 * span))) - span;
    endfunction

    // Magnitude close to full scale, random sign
    function automatic longint near_full_scale();
        longint mag;
        mag = full_scale - longint'($urandom_range(1000));
        return ($urandom_range(1) == 1) ? mag : -mag;
    endfunction

    // One sample through three floor-rounded, clamped DF-I stages
    task automatic model_step(input longint x, output longint y, output bit hit);
        longint acc;
        longint v;
        v = x;
        hit = 0;
        for (int s = 0; s < ns; s++) begin
            acc = active_m[s][0] * v + active_m[s][1] * hx1[s] + active_m[s][2] * hx2[s]
                - active_m[s][3] * hy1[s] - active_m[s][4] * hy2[s];
            acc = acc >>> 14;
            if (acc > full_scale) begin
                acc = full_scale;
                hit = 1;
            end else if (acc < -full_scale - 1) begin
                acc = -full_scale - 1;
                hit = 1;
            end
            hx2[s] = hx1[s];
            hx1[s] = v;
            hy2[s] = hy1[s];
            hy1[s] = acc;
            v = acc;
        end
        y = v;
    endtask

    // Strobe one sample, then idle so the next one starts with an empty cascade
    task automatic send_sample(input longint x);
        longint y;
        bit hit;
        model_step(x, y, hit);
        clip_m = clip_m | hit;
        exp_sample.push_back(audio_eq_pkg::sample_t'(bypass ? x : y));
        exp_clip.push_back(clip_m);
        sample_in = audio_eq_pkg::sample_t'(x);
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (5) @(negedge clk);
    endtask

    task automatic write_coef(input int sec, input int idx, input longint value);
        coef_we = 1'b1;
        coef_addr = audio_eq_pkg::coef_addr_t'(sec * nc + idx);
        coef_data = audio_eq_pkg::coef_t'(value);
        shadow_m[sec][idx] = value;
        @(negedge clk);
        coef_we = 1'b0;
    endtask

    // b taps within +-0.5, feedback taps within +-0.125
    task automatic program_random();
        for (int s = 0; s < ns; s++) begin
            for (int c = 0; c < nc; c++) begin
                write_coef(s, c, (c < 3) ? rand_signed(8192) : rand_signed(2048));
            end
        end
    endtask

    task automatic commit_coefs();
        coef_commit = 1'b1;
        @(negedge clk);
        coef_commit = 1'b0;
        active_m = shadow_m;
    endtask

    task automatic clear_clip();
        clip_clear = 1'b1;
        @(negedge clk);
        clip_clear = 1'b0;
        clip_m = 0;
    endtask

    // Outputs are compared on the falling edge, half a cycle after they change
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_sample.size() == 0) begin
                report_failure("out_valid seen with no sample pending");
            end else begin
                check_value("out_sample", out_sample, exp_sample.pop_front());
                check_value("clip", clip, exp_clip.pop_front());
            end
        end
        if (u_dut.u_properties.fail_count != 0) begin
            report_failure("a concurrent timing property failed");
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            report_failure("timeout: run did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h9952_cd62));
        clk = 1'b0;
        reset = 1'b1;
        sample_in = '0;
        in_valid = 1'b0;
        coef_we = 1'b0;
        coef_addr = '0;
        coef_data = '0;
        coef_commit = 1'b0;
        bypass = 1'b0;
        clip_clear = 1'b0;
        cycle_count = 0;
        clip_m = 0;
        // Unity defaults and empty histories, as after reset
        for (int s = 0; s < ns; s++) begin
            for (int c = 0; c < nc; c++) begin
                shadow_m[s][c] = (c == 0) ? 16384 : 0;
            end
            hx1[s] = 0;
            hx2[s] = 0;
            hy1[s] = 0;
            hy2[s] = 0;
        end
        active_m = shadow_m;
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", out_valid, '0);
            check_value("clip", clip, '0);
            check_value("out_sample", out_sample, '0);
        end
        reset = 1'b0;
        // Passthrough with the default coefficients
        repeat (10) send_sample(rand_signed(full_scale));
        program_random();
        commit_coefs();
        repeat (150) send_sample(rand_signed(full_scale));
        // New set waits in the shadow registers until the commit
        program_random();
        repeat (20) send_sample(rand_signed(full_scale));
        commit_coefs();
        repeat (20) send_sample(rand_signed(full_scale));
        // b0 near 1.99, everything else zero
        for (int s = 0; s < ns; s++) begin
            for (int c = 0; c < nc; c++) begin
                write_coef(s, c, (c == 0) ? 32604 : 0);
            end
        end
        commit_coefs();
        // Flag starts low so the burst has to raise it
        clear_clip();
        repeat (20) send_sample(near_full_scale());
        clear_clip();
        repeat (20) send_sample(rand_signed(1000));
        program_random();
        commit_coefs();
        bypass = 1'b1;
        repeat (30) send_sample(rand_signed(full_scale));
        bypass = 1'b0;
        repeat (30) send_sample(rand_signed(full_scale));
        while (exp_sample.size() != 0) @(negedge clk);
        if (u_dut.u_properties.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_failure("a concurrent timing property failed");
        end
    end

endmodule

//--- tb/audio_eq_properties.sv
`timescale 1ns/1ns
// Timing and reset properties of the equalizer top, attached with bind
// Assumes input strobes at least num_sections + 1 cycles apart
module audio_eq_properties (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic out_valid,
    input audio_eq_pkg::sample_t out_sample,
    input logic clip,
    input logic clip_clear
);

    // Count of failed properties, read by the testbench
    int fail_count = 0;

    // Fixed latency through the sections and the output register
    a_latency: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##(audio_eq_pkg::num_sections + 1) out_valid)
    else begin
        $error("out_valid missing after in_valid");
        fail_count++;
    end

    // Every output belongs to an earlier input
    a_no_orphan: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, audio_eq_pkg::num_sections + 1))
    else begin
        $error("out_valid without a matching in_valid");
        fail_count++;
    end

    // Quiet outputs on every cycle after a reset cycle, so also the first one after reset
    a_reset_quiet: assert property (@(posedge clk)
        reset |=> (!out_valid && !clip && out_sample == '0))
    else begin
        $error("outputs not idle around reset");
        fail_count++;
    end

    // Sticky until cleared
    a_clip_sticky: assert property (@(posedge clk) disable iff (reset)
        (clip && !clip_clear) |=> clip)
    else begin
        $error("clip dropped without clip_clear");
        fail_count++;
    end

endmodule

bind audio_eq_top audio_eq_properties u_properties (.*);

//--- design/audio_eq_top.sv
`timescale 1ns/1ns
// Three-stage biquad equalizer, mono, no back-pressure on the output
// Input strobes must be at least num_sections + 1 cycles apart
module audio_eq_top (
    input  logic clk,
    input  logic reset,
    input  audio_eq_pkg::sample_t sample_in,
    input  logic in_valid,
    input  logic coef_we,
    input  audio_eq_pkg::coef_addr_t coef_addr,
    input  audio_eq_pkg::coef_t coef_data,
    input  logic coef_commit,
    input  logic bypass,
    input  logic clip_clear,
    output audio_eq_pkg::sample_t out_sample,
    output logic out_valid,
    output logic clip
);

    // Active coefficients, one slice per section
    audio_eq_pkg::coef_t coef_b0 [audio_eq_pkg::num_sections];
    audio_eq_pkg::coef_t coef_b1 [audio_eq_pkg::num_sections];
    audio_eq_pkg::coef_t coef_b2 [audio_eq_pkg::num_sections];
    audio_eq_pkg::coef_t coef_a1 [audio_eq_pkg::num_sections];
    audio_eq_pkg::coef_t coef_a2 [audio_eq_pkg::num_sections];

    // Cascade links, entry 0 is the input and the last entry the final section
    audio_eq_pkg::sample_t stage_sample [audio_eq_pkg::num_sections+1];
    logic [audio_eq_pkg::num_sections:0] stage_valid;
    logic [audio_eq_pkg::num_sections-1:0] sec_saturated;

    coef_bank u_coef_bank (
        .clk (clk),
        .reset (reset),
        .coef_we (coef_we),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .coef_commit (coef_commit),
        .b0 (coef_b0),
        .b1 (coef_b1),
        .b2 (coef_b2),
        .a1 (coef_a1),
        .a2 (coef_a2)
    );

    // Head of the chain
    assign stage_sample[0] = sample_in;
    assign stage_valid[0] = in_valid;

    // Section k reads link k and drives link k + 1
    for (genvar k = 0; k < audio_eq_pkg::num_sections; k++) begin : g_section
        biquad_section u_section (
            .clk (clk),
            .reset (reset),
            .in_valid (stage_valid[k]),
            .in_sample (stage_sample[k]),
            .b0 (coef_b0[k]),
            .b1 (coef_b1[k]),
            .b2 (coef_b2[k]),
            .a1 (coef_a1[k]),
            .a2 (coef_a2[k]),
            .out_valid (stage_valid[k+1]),
            .out_sample (stage_sample[k+1]),
            .saturated (sec_saturated[k])
        );
    end

    // Dry copy taken straight from the input port
    output_stage u_output_stage (
        .clk (clk),
        .reset (reset),
        .in_valid (in_valid),
        .dry_sample (sample_in),
        .wet_valid (stage_valid[audio_eq_pkg::num_sections]),
        .wet_sample (stage_sample[audio_eq_pkg::num_sections]),
        .saturated (sec_saturated),
        .bypass (bypass),
        .clip_clear (clip_clear),
        .out_valid (out_valid),
        .out_sample (out_sample),
        .clip (clip)
    );

endmodule

//--- design/output_stage.sv
`timescale 1ns/1ns
// Wet/dry select and sticky clip flag at the end of the cascade
// The dry hold relies on input strobes at least num_sections + 1 cycles apart
module output_stage (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  audio_eq_pkg::sample_t dry_sample,
    input  logic wet_valid,
    input  audio_eq_pkg::sample_t wet_sample,
    input  logic [audio_eq_pkg::num_sections-1:0] saturated,
    input  logic bypass,
    input  logic clip_clear,
    output logic out_valid,
    output audio_eq_pkg::sample_t out_sample,
    output logic clip
);

    // Unfiltered copy of the sample now in the cascade
    audio_eq_pkg::sample_t dry_hold;
    logic any_sat;

    // Overwritten only after the matching wet sample has left
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dry_hold <= dry_sample;
        end
    end

    // Pulses from different sections arrive in different cycles
    assign any_sat = |saturated;

    // Output register, one cycle behind the last section
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_sample <= '0;
        end else begin
            out_valid <= wet_valid;
            if (wet_valid) begin
                // Bypass picks the dry copy, same latency either way
                out_sample <= bypass ? dry_hold : wet_sample;
            end
        end
    end

    // Sticky clip, a set in the clear cycle wins
    // Still tracked under bypass since the sections keep running
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clip <= 1'b0;
        end else if (any_sat) begin
            clip <= 1'b1;
        end else if (clip_clear) begin
            clip <= 1'b0;
        end
    end

endmodule

//--- design/biquad_section.sv
`timescale 1ns/1ns
// Direct-form-I biquad with Q2.14 coefficients and floor rounding
// Advances only on in_valid; coefficients are sampled in that same cycle
module biquad_section (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  audio_eq_pkg::sample_t in_sample,
    input  audio_eq_pkg::coef_t b0,
    input  audio_eq_pkg::coef_t b1,
    input  audio_eq_pkg::coef_t b2,
    input  audio_eq_pkg::coef_t a1,
    input  audio_eq_pkg::coef_t a2,
    output logic out_valid,
    output audio_eq_pkg::sample_t out_sample,
    output logic saturated
);

    // Input history, x[n-1] and x[n-2]
    audio_eq_pkg::sample_t x1;
    audio_eq_pkg::sample_t x2;
    // Output history, y[n-1] and y[n-2], already saturated
    audio_eq_pkg::sample_t y1;
    audio_eq_pkg::sample_t y2;

    // Products
    audio_eq_pkg::prod_t p_b0;
    audio_eq_pkg::prod_t p_b1;
    audio_eq_pkg::prod_t p_b2;
    audio_eq_pkg::prod_t p_a1;
    audio_eq_pkg::prod_t p_a2;

    // Sum and its scaled form
    audio_eq_pkg::acc_t acc;
    audio_eq_pkg::acc_t acc_scaled;

    // Next output after clamping
    audio_eq_pkg::sample_t y_sat;
    logic y_clipped;

    // 16 x 24 signed multiplies, 40-bit results
    assign p_b0 = b0 * in_sample;
    assign p_b1 = b1 * x1;
    assign p_b2 = b2 * x2;
    assign p_a1 = a1 * y1;
    assign p_a2 = a2 * y2;

    // Sign extend every product before the sum
    // Feedback terms are subtracted
    assign acc = audio_eq_pkg::acc_t'(p_b0)
               + audio_eq_pkg::acc_t'(p_b1)
               + audio_eq_pkg::acc_t'(p_b2)
               - audio_eq_pkg::acc_t'(p_a1)
               - audio_eq_pkg::acc_t'(p_a2);

    // Drop the Q2.14 fraction, rounds toward minus infinity
    assign acc_scaled = acc >>> audio_eq_pkg::coef_frac_bits;

    // Clamp to the 24-bit range
    always_comb begin
        if (acc_scaled > audio_eq_pkg::acc_t'(audio_eq_pkg::sample_max)) begin
            y_sat = audio_eq_pkg::sample_max;
            y_clipped = 1'b1;
        end else if (acc_scaled < audio_eq_pkg::acc_t'(audio_eq_pkg::sample_min)) begin
            y_sat = audio_eq_pkg::sample_min;
            y_clipped = 1'b1;
        end else begin
            y_sat = audio_eq_pkg::sample_t'(acc_scaled);
            y_clipped = 1'b0;
        end
    end

    // Valid and clip pulse, one cycle behind in_valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            saturated <= 1'b0;
        end else begin
            out_valid <= in_valid;
            saturated <= in_valid & y_clipped;
        end
    end

    // Result and histories move only with a sample
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_sample <= '0;
            x1 <= '0;
            x2 <= '0;
            y1 <= '0;
            y2 <= '0;
        end else if (in_valid) begin
            out_sample <= y_sat;
            x2 <= x1;
            x1 <= in_sample;
            // Feedback uses the clamped value, same as the output
            y2 <= y1;
            y1 <= y_sat;
        end
    end

endmodule

//--- design/coef_bank.sv
`timescale 1ns/1ns
// Shadow and active coefficient sets; writes to addresses 15 and above are dropped
// A write in the same cycle as a commit reaches the active set only on the next commit
module coef_bank (
    input  logic clk,
    input  logic reset,
    input  logic coef_we,
    input  audio_eq_pkg::coef_addr_t coef_addr,
    input  audio_eq_pkg::coef_t coef_data,
    input  logic coef_commit,
    output audio_eq_pkg::coef_t b0 [audio_eq_pkg::num_sections],
    output audio_eq_pkg::coef_t b1 [audio_eq_pkg::num_sections],
    output audio_eq_pkg::coef_t b2 [audio_eq_pkg::num_sections],
    output audio_eq_pkg::coef_t a1 [audio_eq_pkg::num_sections],
    output audio_eq_pkg::coef_t a2 [audio_eq_pkg::num_sections]
);

    audio_eq_pkg::coef_t shadow [audio_eq_pkg::num_sections][audio_eq_pkg::coefs_per_section];
    audio_eq_pkg::coef_t active [audio_eq_pkg::num_sections][audio_eq_pkg::coefs_per_section];
    logic addr_ok;

    // Passthrough default, b0 = 1.0 and the rest zero
    function automatic audio_eq_pkg::coef_t default_coef(input int idx);
        return (idx == audio_eq_pkg::idx_b0) ? audio_eq_pkg::coef_unity : '0;
    endfunction

    // Addresses past the last section fall outside every slot
    assign addr_ok = (int'(coef_addr) < audio_eq_pkg::num_coefs);

    // Shadow set, one coefficient per write strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < audio_eq_pkg::num_sections; s++) begin
                for (int c = 0; c < audio_eq_pkg::coefs_per_section; c++) begin
                    shadow[s][c] <= default_coef(c);
                end
            end
        end else if (coef_we && addr_ok) begin
            // Decode flat address into section and index
            for (int s = 0; s < audio_eq_pkg::num_sections; s++) begin
                for (int c = 0; c < audio_eq_pkg::coefs_per_section; c++) begin
                    if (int'(coef_addr) == s * audio_eq_pkg::coefs_per_section + c) begin
                        shadow[s][c] <= coef_data;
                    end
                end
            end
        end
    end

    // Active set, whole copy on commit so no section sees a mixed set
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < audio_eq_pkg::num_sections; s++) begin
                for (int c = 0; c < audio_eq_pkg::coefs_per_section; c++) begin
                    active[s][c] <= default_coef(c);
                end
            end
        end else if (coef_commit) begin
            active <= shadow;
        end
    end

    // Per-section buses from the active set only
    always_comb begin
        for (int s = 0; s < audio_eq_pkg::num_sections; s++) begin
            b0[s] = active[s][audio_eq_pkg::idx_b0];
            b1[s] = active[s][audio_eq_pkg::idx_b1];
            b2[s] = active[s][audio_eq_pkg::idx_b2];
            a1[s] = active[s][audio_eq_pkg::idx_a1];
            a2[s] = active[s][audio_eq_pkg::idx_a2];
        end
    end

endmodule

//--- design/audio_eq_pkg.sv
// Widths and constants shared by the biquad equalizer
// Coefficients are Q2.14, so the usable range is -2.0 up to just under +2.0
package audio_eq_pkg;

    // Bit widths
    localparam int sample_width = 24;
    localparam int coef_width = 16;
    localparam int prod_width = sample_width + coef_width;
    // Two guard bits hold the sum of five full-scale products
    localparam int acc_width = prod_width + 2;
    localparam int coef_addr_width = 4;

    // Signed audio sample
    typedef logic signed [sample_width-1:0] sample_t;
    // Signed Q2.14 coefficient
    typedef logic signed [coef_width-1:0] coef_t;
    // One coefficient times one sample
    typedef logic signed [prod_width-1:0] prod_t;
    // Biquad accumulator
    typedef logic signed [acc_width-1:0] acc_t;
    // Flat address, section * 5 + index
    typedef logic [coef_addr_width-1:0] coef_addr_t;

    // Cascade shape
    localparam int num_sections = 3;
    localparam int coefs_per_section = 5;
    localparam int num_coefs = num_sections * coefs_per_section;

    // Coefficient order inside a section
    localparam int idx_b0 = 0;
    localparam int idx_b1 = 1;
    localparam int idx_b2 = 2;
    localparam int idx_a1 = 3;
    localparam int idx_a2 = 4;

    // Q2.14 scaling
    localparam int coef_frac_bits = 14;
    localparam coef_t coef_unity = coef_t'(16384);

    // Saturation limits
    localparam sample_t sample_max = {1'b0, {(sample_width-1){1'b1}}};
    localparam sample_t sample_min = {1'b1, {(sample_width-1){1'b0}}};

endpackage
